// ==== filelist.f ====
tone_pkg.sv
tone_apb_regs.sv
tone_triangle_stage.sv
tone_shape_stage.sv
tone_output_stage.sv
tone_synth_top.sv
tb_tone_synth.sv

// ==== Bender.yml ====
package:
  name: tone_synth

sources:
  - tone_pkg.sv
  - tone_apb_regs.sv
  - tone_triangle_stage.sv
  - tone_shape_stage.sv
  - tone_output_stage.sv
  - tone_synth_top.sv
  - target: simulation
    files:
      - tb_tone_synth.sv

// ==== tb_tone_synth.sv ====
`timescale 1ns/1ps

module tb_tone_synth;
    import tone_pkg::*;

    logic                       clk;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [APB_ADDR_W-1:0]      paddr;
    logic [APB_DATA_W-1:0]      pwdata;
    logic [APB_DATA_W-1:0]      prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       sample_valid;
    logic                       sample_ready;
    logic signed [SAMPLE_W-1:0] sample_data;

    int                         cycle_no;
    logic signed [SAMPLE_W-1:0] cap_data[$];  // accepted samples in arrival order
    int                         cap_time[$];  // cycle of each acceptance
    int                         m_val;        // oscillator model value
    bit                         m_up;         // model direction where 1 means rising

    tone_synth_top dut0 (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;                    // 40 ns period

    always @(posedge clk) cycle_no <= cycle_no + 1;

    // --------------------------------------------------
    // error exit and compare tasks
    // --------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] exp,
                                input logic signed [SAMPLE_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_reg(input string name, input logic [APB_DATA_W-1:0] exp,
                             input logic [APB_DATA_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_count(input string name, input logic [DROP_W-1:0] exp,
                               input logic [DROP_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    endtask

    // --------------------------------------------------
    // bus and stream helpers
    // --------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        #2;
        psel    = 1'b1;                       // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2 penable = 1'b1;                    // access phase
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 16)
                stop_run("APB slave never raised pready");
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                       // write lands on this edge
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic err);
        logic [APB_DATA_W-1:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    // sampled at negedge so the transfer lands on the following rising edge
    task automatic capture_samples(input int n, input int limit);
        int waited;
        cap_data.delete();
        cap_time.delete();
        waited = 0;
        while (cap_data.size() < n) begin
            @(negedge clk);
            if (sample_valid && sample_ready) begin
                cap_data.push_back(sample_data);
                cap_time.push_back(cycle_no);
            end
            waited++;
            if (waited > limit)
                stop_run("expected samples never arrived on the stream");
        end
    endtask

    // reset and program the tone before enabling it
    task automatic start_tone(input wave_sel_e wave, input int step, input int amp,
                              input int rate);
        logic err;
        apply_reset();
        apb_write(REG_STEP, step, err);
        apb_write(REG_AMP, amp, err);
        apb_write(REG_RATE, rate, err);
        apb_write(REG_CTRL, {29'd0, wave, 1'b1}, err);
        m_val = 0;                            // oscillator restarts at 0 going up
        m_up  = 1'b1;
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // one tick of the up/down rule that returns 1 when the value went up
    // steps stay small so the 16-bit saturation never kicks in
    function automatic bit model_tick(input int step, input int amp);
        bit up_add;
        up_add = 1'b0;
        if ((m_up && m_val > amp) || (!m_up && m_val < -amp)) begin
            m_up = !m_up;                     // turn and hold the value
        end else begin
            up_add = m_up;
            m_val  = m_up ? m_val + step : m_val - step;
        end
        return up_add;
    endfunction

    function automatic int square_of(input int t, input int amp);
        if (t >= amp / 64)
            return amp;
        else if (t <= -(amp / 64))
            return -amp;
        return 0;                             // dead band
    endfunction

    function automatic int sign_of(input int v);
        if (v > 0)
            return 1;
        else if (v < 0)
            return -1;
        return 0;
    endfunction

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_registers();
        logic [APB_ADDR_W-1:0] addrs[4];
        logic [APB_DATA_W-1:0] vals[4];
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        addrs[0] = REG_CTRL;
        addrs[1] = REG_STEP;
        addrs[2] = REG_AMP;
        addrs[3] = REG_RATE;
        vals[0]  = $urandom % 8;              // enable + wave
        vals[1]  = $urandom % 65536;
        vals[2]  = $urandom % 30001;          // legal amp range
        vals[3]  = $urandom % 65536;
        for (int i = 0; i < 4; i++) begin
            apb_write(addrs[i], vals[i], err);
            check_reg("registers: write pslverr", 0, err);
            apb_read(addrs[i], rd, err);
            check_reg("registers: read pslverr", 0, err);
            check_reg("registers: readback", vals[i], rd);
        end
        apb_write(REG_AMP, 40000, err);
        apb_read(REG_AMP, rd, err);
        check_reg("registers: amp clamp", 30000, rd);
        apb_read(5'h14, rd, err);
        check_reg("registers: unmapped pslverr", 1, err);
    endtask

    task automatic test_triangle();
        int step;
        int rate;
        step = 100 + ($urandom % 900);
        rate = 5;
        start_tone(WAVE_TRIANGLE, step, 8000, rate);
        capture_samples(200, 200 * rate + 50);
        for (int i = 0; i < 200; i++) begin
            void'(model_tick(step, 8000));
            check_sample("triangle: value", SAMPLE_W'(m_val), cap_data[i]);
            if (i > 0)
                check_count("triangle: period", DROP_W'(rate),
                            DROP_W'(cap_time[i] - cap_time[i-1]));
        end
    endtask

    task automatic test_square();
        int step;
        step = 100 + ($urandom % 900);
        start_tone(WAVE_SQUARE, step, 8000, 4);
        capture_samples(200, 200 * 4 + 50);
        for (int i = 0; i < 200; i++) begin
            void'(model_tick(step, 8000));
            check_sample("square: value", SAMPLE_W'(square_of(m_val, 8000)), cap_data[i]);
        end
    endtask

    task automatic test_sine();
        int step;
        int s;
        int hi;
        int lo;
        bit up_add;
        step = 300 + ($urandom % 500);
        hi   = -100000;
        lo   = 100000;
        start_tone(WAVE_SINE, step, 12000, 4);
        capture_samples(200, 200 * 4 + 50);
        for (int i = 0; i < 200; i++) begin
            up_add = model_tick(step, 12000);
            s      = cap_data[i];
            if (up_add) begin                 // rising half only
                check_sample("sine: sign", SAMPLE_W'(sign_of(m_val)), SAMPLE_W'(sign_of(s)));
                if (i > 0 && s < cap_data[i-1])
                    stop_run($sformatf("[FAIL] sine: rising expected at least %0d actual %0d",
                                       cap_data[i-1], s));
            end
            if (s > 12000 || s < -12000)
                stop_run($sformatf("[FAIL] sine: bound expected |s| <= 12000 actual %0d", s));
            hi = (s > hi) ? s : hi;
            lo = (s < lo) ? s : lo;
        end
        if (hi + lo > 2 || hi + lo < -2)
            stop_run($sformatf("[FAIL] sine: symmetry expected max+min within 2 actual %0d",
                               hi + lo));
    endtask

    task automatic test_off_and_enable();
        logic err;
        start_tone(WAVE_OFF, 500, 8000, 6);
        capture_samples(20, 20 * 6 + 50);
        foreach (cap_data[i])
            check_sample("off: value", 0, cap_data[i]);
        apb_write(REG_CTRL, 0, err);
        repeat (4) @(negedge clk);            // let in-flight samples drain
        for (int i = 0; i < 4 * 6; i++) begin
            @(negedge clk);
            if (sample_valid)
                stop_run("sample_valid appeared after enable was cleared");
        end
    endtask

    task automatic test_backpressure();
        int                         n;
        int                         rate;
        int                         waited;
        logic signed [SAMPLE_W-1:0] held;
        logic [APB_DATA_W-1:0]      rd;
        logic                       err;
        n    = 3 + ($urandom % 6);            // stall length in ticks
        rate = 8;
        start_tone(WAVE_TRIANGLE, 700, 8000, rate);
        sample_ready = 1'b0;                  // stall before the first tick
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 4 * rate)
                stop_run("first sample never reached the output");
        end while (!sample_valid);
        held = sample_data;
        check_sample("backpressure: first", 700, held);
        for (int i = 0; i < (n - 1) * rate; i++) begin
            @(negedge clk);
            if (!sample_valid)
                stop_run("held sample vanished while sample_ready was low");
            check_sample("backpressure: stable", held, sample_data);
        end
        apb_read(REG_DROP, rd, err);
        check_count("backpressure: drops", DROP_W'(n - 1), rd[DROP_W-1:0]);
        sample_ready = 1'b1;                  // release so the held sample goes out
        @(negedge clk);
        if (!sample_valid)
            stop_run("held sample was not offered after sample_ready rose");
        check_sample("backpressure: release", held, sample_data);
        @(negedge clk);
        if (sample_valid)
            stop_run("held sample was not taken after sample_ready rose");
        apb_write(REG_DROP, 1, err);
        apb_read(REG_DROP, rd, err);
        check_count("backpressure: clear", 0, rd[DROP_W-1:0]);
    endtask

    initial begin
        void'($urandom(32'h7f50));
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        sample_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        test_registers();
        test_triangle();
        test_square();
        test_sine();
        test_off_and_enable();
        test_backpressure();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tone_synth_top.sv ====
`timescale 1ns/1ps

module tone_synth_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [tone_pkg::APB_ADDR_W-1:0]      paddr,
    input  logic [tone_pkg::APB_DATA_W-1:0]      pwdata,
    output logic [tone_pkg::APB_DATA_W-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 sample_valid,
    input  logic                                 sample_ready,
    output logic signed [tone_pkg::SAMPLE_W-1:0] sample_data
);
    import tone_pkg::*;

    tone_cfg_t          cfg;         // live settings to all stages
    logic               drop_clear;
    logic [DROP_W-1:0]  drop_count;
    tri_point_t         tri_pt;
    tone_sample_t       shaped;

    // --------------------------------------------------
    // register block beside the pipeline
    // --------------------------------------------------
    tone_apb_regs u_regs (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .cfg, .drop_clear, .drop_count
    );

    // --------------------------------------------------
    // triangle -> shaper -> output buffer
    // --------------------------------------------------
    tone_triangle_stage u_tri (
        .clk, .reset, .cfg, .tri_pt
    );

    tone_shape_stage u_shape (
        .clk, .reset, .cfg, .tri_pt, .shaped
    );

    tone_output_stage u_out (
        .clk, .reset, .shaped,
        .sample_valid, .sample_data, .sample_ready,
        .drop_clear, .drop_count
    );

endmodule

// ==== tone_output_stage.sv ====
`timescale 1ns/1ps

module tone_output_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  tone_pkg::tone_sample_t               shaped,
    output logic                                 sample_valid,
    output logic signed [tone_pkg::SAMPLE_W-1:0] sample_data,
    input  logic                                 sample_ready,
    input  logic                                 drop_clear,
    output logic [tone_pkg::DROP_W-1:0]          drop_count
);
    import tone_pkg::*;

    logic                       buf_valid;
    logic signed [SAMPLE_W-1:0] buf_data;
    logic                       pop;    // sink takes the held sample
    logic                       load;
    logic                       drop;   // buffer full, nowhere to put it

    assign pop  = buf_valid & sample_ready;
    assign load = shaped.valid & (~buf_valid | pop);
    assign drop = shaped.valid & buf_valid & ~sample_ready;

    // --------------------------------------------------
    // one-entry holding register
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            buf_valid <= 1'b0;
        else if (load)
            buf_valid <= 1'b1;
        else if (pop)
            buf_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load)
            buf_data <= shaped.value;   // held steady while stalled
    end

    assign sample_valid = buf_valid;
    assign sample_data  = buf_data;

    // saturating drop counter, clear wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            drop_count <= '0;
        else if (drop_clear)
            drop_count <= '0;
        else if (drop && (drop_count != '1))
            drop_count <= drop_count + 1'b1;
    end

endmodule

// ==== tone_shape_stage.sv ====
`timescale 1ns/1ps

module tone_shape_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  tone_pkg::tone_cfg_t    cfg,
    input  tone_pkg::tri_point_t   tri_pt,
    output tone_pkg::tone_sample_t shaped
);
    import tone_pkg::*;

    // slope helpers, shift-and-add only
    function automatic logic [SHAPE_W-1:0] slope_148(input logic [SHAPE_W-1:0] x);
        return x + (x >> 1) - (x >> 6);
    endfunction

    function automatic logic [SHAPE_W-1:0] slope_063(input logic [SHAPE_W-1:0] x);
        return (x >> 1) + (x >> 3);
    endfunction

    function automatic logic [SHAPE_W-1:0] slope_016(input logic [SHAPE_W-1:0] x);
        return (x >> 3) + (x >> 5);
    endfunction

    logic signed [SAMPLE_W:0]   t_w;        // triangle, one bit of headroom
    logic signed [SAMPLE_W:0]   amp_s;
    logic signed [SAMPLE_W:0]   sq_thr;
    logic [SHAPE_W-1:0]         mag;
    logic [SHAPE_W-1:0]         amp_x;
    logic [SHAPE_W-1:0]         a;
    logic [SHAPE_W-1:0]         b1, b2, b3;
    logic [SHAPE_W-1:0]         y1, y2, y3;
    logic [SHAPE_W-1:0]         sine_raw;
    logic [SHAPE_W-1:0]         sine_mag;
    logic signed [SAMPLE_W-1:0] sine_s;
    logic signed [SAMPLE_W-1:0] sine_val;
    logic signed [SAMPLE_W-1:0] square_val;
    logic signed [SAMPLE_W-1:0] sel_val;
    logic                       out_valid;
    logic signed [SAMPLE_W-1:0] out_value;

    assign t_w   = {tri_pt.value[SAMPLE_W-1], tri_pt.value};
    assign amp_s = {1'b0, cfg.amp};
    assign amp_x = {2'b00, cfg.amp};
    assign mag   = (t_w < 0) ? SHAPE_W'($unsigned(-t_w)) : SHAPE_W'($unsigned(t_w));
    assign a     = (mag > amp_x) ? amp_x : mag;   // overshoot past amp sits on the peak

    // --------------------------------------------------
    // sine, four segments on |t|
    // --------------------------------------------------
    assign b1 = (amp_x >> 2) + (amp_x >> 3) + (amp_x >> 4);  // 0.44 amp
    assign b2 = (amp_x >> 1) + (amp_x >> 3);                 // 0.63 amp
    assign b3 = b2 + (amp_x >> 2);                           // 0.88 amp

    // each segment starts where the last one ended, so the curve never steps down
    assign y1 = slope_148(b1);
    assign y2 = y1 + (b2 - b1);
    assign y3 = y2 + slope_063(b3 - b2);

    always_comb begin
        if (a < b1)      sine_raw = slope_148(a);           // 1.48
        else if (a < b2) sine_raw = y1 + (a - b1);          // 1.00
        else if (a < b3) sine_raw = y2 + slope_063(a - b2); // 0.63
        else             sine_raw = y3 + slope_016(a - b3); // 0.16, flat top near peak
    end

    assign sine_mag = (sine_raw > amp_x) ? amp_x : sine_raw;
    assign sine_s   = $signed(sine_mag[SAMPLE_W-1:0]);  // <= 30000, sign bit clear
    assign sine_val = (t_w < 0) ? -sine_s : sine_s;     // odd symmetry

    // --------------------------------------------------
    // square slicer, small dead band around 0
    // --------------------------------------------------
    assign sq_thr = amp_s >>> 6;

    always_comb begin
        if (t_w >= sq_thr)       square_val = amp_s[SAMPLE_W-1:0];
        else if (t_w <= -sq_thr) square_val = -amp_s[SAMPLE_W-1:0];
        else                     square_val = '0;
    end

    always_comb begin
        case (cfg.wave)
            WAVE_SINE:     sel_val = sine_val;
            WAVE_TRIANGLE: sel_val = tri_pt.value;
            WAVE_SQUARE:   sel_val = square_val;
            default:       sel_val = '0;            // WAVE_OFF
        endcase
    end

    // one cycle of latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= tri_pt.valid;
    end

    always_ff @(posedge clk) begin
        if (tri_pt.valid)
            out_value <= sel_val;
    end

    assign shaped = '{valid: out_valid, value: out_value};

endmodule

// ==== tone_triangle_stage.sv ====
`timescale 1ns/1ps

module tone_triangle_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  tone_pkg::tone_cfg_t  cfg,
    output tone_pkg::tri_point_t tri_pt
);
    import tone_pkg::*;

    logic [15:0]                div_cnt;
    logic [15:0]                div_last;   // terminal count, rate_div - 1
    logic                       tick;
    logic                       rising;     // direction of the ramp
    logic                       tri_valid;
    logic signed [SAMPLE_W-1:0] tri_value;
    logic signed [SAMPLE_W-1:0] tri_next;
    logic signed [SHAPE_W-1:0]  val_w;
    logic signed [SHAPE_W-1:0]  amp_w;
    logic signed [SHAPE_W-1:0]  step_w;
    logic signed [SHAPE_W-1:0]  sum_w;
    logic                       turn;

    // --------------------------------------------------
    // sample-rate divider
    // --------------------------------------------------
    assign div_last = (cfg.rate_div < RATE_MIN) ? (RATE_MIN - 16'd1) : (cfg.rate_div - 16'd1);
    assign tick     = cfg.enable & (div_cnt == div_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            div_cnt <= '0;
        else if (!cfg.enable || tick)
            div_cnt <= '0;             // disable restarts the period
        else
            div_cnt <= div_cnt + 16'd1;
    end

    // --------------------------------------------------
    // up/down oscillator
    // --------------------------------------------------
    assign val_w  = {{2{tri_value[SAMPLE_W-1]}}, tri_value};
    assign amp_w  = {2'b00, cfg.amp};
    assign step_w = {2'b00, cfg.step};
    assign turn   = rising ? (val_w > amp_w) : (val_w < -amp_w);  // past the peak
    assign sum_w  = rising ? (val_w + step_w) : (val_w - step_w);

    // saturate so a large step cannot wrap the sign
    always_comb begin
        if (sum_w > SAMPLE_HI)      tri_next = SAMPLE_W'(SAMPLE_HI);
        else if (sum_w < SAMPLE_LO) tri_next = SAMPLE_W'(SAMPLE_LO);
        else                        tri_next = sum_w[SAMPLE_W-1:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tri_value <= '0;
            rising    <= 1'b1;
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= tick;           // one-cycle strobe per sample
            if (tick && turn)
                rising    <= ~rising;    // value held on the turn
            else if (tick)
                tri_value <= tri_next;
        end
    end

    assign tri_pt = '{valid: tri_valid, value: tri_value};

endmodule

// ==== tone_apb_regs.sv ====
`timescale 1ns/1ps

module tone_apb_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [tone_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [tone_pkg::APB_DATA_W-1:0] pwdata,
    output logic [tone_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    output tone_pkg::tone_cfg_t             cfg,
    output logic                            drop_clear,
    input  logic [tone_pkg::DROP_W-1:0]     drop_count
);
    import tone_pkg::*;

    logic      access;   // access phase of a transfer
    logic      addr_hit; // one of the five offsets
    logic      wr_en;
    tone_cfg_t cfg_q;

    assign access = psel & penable;

    always_comb begin
        case (paddr)
            REG_CTRL, REG_STEP, REG_AMP, REG_RATE, REG_DROP: addr_hit = 1'b1;
            default:                                         addr_hit = 1'b0;
        endcase
    end

    assign wr_en      = access & pwrite & addr_hit;  // bad address never writes
    assign pready     = 1'b1;                        // zero wait states
    assign pslverr    = access & ~addr_hit;
    assign drop_clear = wr_en & (paddr == REG_DROP); // data ignored, any write clears

    // --------------------------------------------------
    // config registers
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_q <= '0;              // disabled, WAVE_OFF, everything zero
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL: begin
                    cfg_q.enable <= pwdata[0];
                    cfg_q.wave   <= wave_sel_e'(pwdata[2:1]);
                end
                REG_STEP: cfg_q.step     <= pwdata[15:0];
                REG_AMP:  cfg_q.amp      <= (pwdata > APB_DATA_W'(AMP_MAX)) ? AMP_MAX
                                                                            : pwdata[15:0];
                REG_RATE: cfg_q.rate_div <= pwdata[15:0];  // floor of 4 applied downstream
                default:  cfg_q          <= cfg_q;         // REG_DROP has no storage here
            endcase
        end
    end

    assign cfg = cfg_q;

    // read mux, zero-extended fields
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL: prdata[2:0]        = {cfg_q.wave, cfg_q.enable};
            REG_STEP: prdata[15:0]       = cfg_q.step;
            REG_AMP:  prdata[15:0]       = cfg_q.amp;
            REG_RATE: prdata[15:0]       = cfg_q.rate_div;
            REG_DROP: prdata[DROP_W-1:0] = drop_count;  // read-only view
            default:  prdata             = '0;
        endcase
    end

endmodule

// ==== tone_pkg.sv ====
package tone_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int SAMPLE_W   = 16;            // signed audio sample
    localparam int APB_ADDR_W = 5;
    localparam int APB_DATA_W = 32;
    localparam int DROP_W     = 16;            // dropped-sample counter
    localparam int SHAPE_W    = SAMPLE_W + 2;  // headroom for shaper math

    localparam int SAMPLE_HI = 32767;          // saturation limits of the oscillator
    localparam int SAMPLE_LO = -32768;

    localparam logic [15:0] AMP_MAX  = 16'd30000;  // keeps the shaper clear of overflow
    localparam logic [15:0] RATE_MIN = 16'd4;      // shortest sample period in clocks

    // --------------------------------------------------
    // register map, byte offsets
    // --------------------------------------------------
    localparam logic [APB_ADDR_W-1:0] REG_CTRL = 5'h00;  // [0] enable, [2:1] wave
    localparam logic [APB_ADDR_W-1:0] REG_STEP = 5'h04;
    localparam logic [APB_ADDR_W-1:0] REG_AMP  = 5'h08;
    localparam logic [APB_ADDR_W-1:0] REG_RATE = 5'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_DROP = 5'h10;  // read count, write clears

    typedef enum logic [1:0] {
        WAVE_OFF      = 2'd0,
        WAVE_SINE     = 2'd1,
        WAVE_TRIANGLE = 2'd2,
        WAVE_SQUARE   = 2'd3
    } wave_sel_e;

    // live configuration, fanned out to every stage
    typedef struct packed {
        logic        enable;
        wave_sel_e   wave;
        logic [15:0] step;      // vertical step per tick
        logic [15:0] amp;       // peak, never above AMP_MAX
        logic [15:0] rate_div;  // clocks per sample
    } tone_cfg_t;

    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] value;
    } tri_point_t;

    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] value;
    } tone_sample_t;

endpackage
